// File: proc_pkg.sv
// shared widths, enums and encodings for the three-stage rv32 subset core
// every rtl module and the testbench model import what they need from here

package proc_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  localparam int XLEN = 32;

  // data word, also used for raw instruction words
  typedef logic [XLEN-1:0] word_t;

  // architectural register number
  typedef logic [4:0] reg_addr_t;

  // ----------------------------------------
  // major opcodes of the kept subset
  // ----------------------------------------

  typedef enum logic [6:0] {
    OP_REG    = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LUI    = 7'b0110111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // alu functions, cp_b passes operand b through
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9,
    ALU_CP_B = 4'd10
  } alu_op_e;

  // manager csr numbers
  localparam logic [11:0] CSR_PROC2MNGR = 12'h7c0;
  localparam logic [11:0] CSR_MNGR2PROC = 12'hfc0;

  // ----------------------------------------
  // funct3 / funct7 codes
  // ----------------------------------------

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // csrw is csrrw with rd = x0, csrr is csrrs with rs1 = x0
  localparam logic [2:0] F3_CSRRW = 3'b001;
  localparam logic [2:0] F3_CSRRS = 3'b010;

  // base and alternate (sub / sra) funct7
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

// File: reg_file.sv
// 32 x 32 register file, two combinational reads and one synchronous write
// x0 is hardwired to zero on both read ports

module reg_file (
  input  logic               clk,
  input  proc_pkg::reg_addr_t rs1_addr_i,
  input  proc_pkg::reg_addr_t rs2_addr_i,
  output proc_pkg::word_t    rs1_data_o,
  output proc_pkg::word_t    rs2_data_o,
  input  logic               wen_i,
  input  proc_pkg::reg_addr_t waddr_i,
  input  proc_pkg::word_t    wdata_i
);

  import proc_pkg::*;

  // storage, entry 0 is never written
  word_t regs [32];

  // write port
  always_ff @(posedge clk) begin
    if (wen_i && (waddr_i != 5'd0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // read ports, x0 forced to zero
  assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

// File: proc_decode.sv
// decode stage: d register, instruction decode, operand select and interlock
// feeds the x register inside proc_execute through the dx_* outputs

module proc_decode (
  input  logic                clk,
  input  logic                reset,
  // instruction stream
  input  logic                inst_val_i,
  output logic                inst_rdy_o,
  input  proc_pkg::word_t     inst_i,
  // manager input stream
  input  logic                mngr2proc_val_i,
  output logic                mngr2proc_rdy_o,
  input  proc_pkg::word_t     mngr2proc_data_i,
  // register file read
  output proc_pkg::reg_addr_t rs1_addr_o,
  output proc_pkg::reg_addr_t rs2_addr_o,
  input  proc_pkg::word_t     rs1_data_i,
  input  proc_pkg::word_t     rs2_data_i,
  // pending writes downstream
  input  logic                x_wen_i,
  input  proc_pkg::reg_addr_t x_waddr_i,
  input  logic                w_wen_i,
  input  proc_pkg::reg_addr_t w_waddr_i,
  input  logic                w_stall_i,
  // to x
  output logic                dx_val_o,
  output proc_pkg::alu_op_e   dx_alu_op_o,
  output proc_pkg::word_t     dx_op_a_o,
  output proc_pkg::word_t     dx_op_b_o,
  output logic                dx_wen_o,
  output proc_pkg::reg_addr_t dx_waddr_o,
  output logic                dx_p2m_o
);

  import proc_pkg::*;

  logic      val_d;
  word_t     inst_d;
  logic      stall_d;
  opcode_e   opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     imm_i;
  word_t     imm_u;
  logic      inst_ok;
  logic      rs1_en;
  logic      rs2_en;
  logic      wen;
  logic      csrr;
  logic      csrw;
  alu_op_e   alu_op;
  word_t     op_b;
  logic      ostall_hazard;
  logic      ostall_mngr;

  // ----------------------------------------
  // d register
  // ----------------------------------------

  // takes a new instruction whenever d is empty or moving on
  assign inst_rdy_o = !stall_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_d <= 1'b0;
    end else if (!stall_d) begin
      val_d  <= inst_val_i;
      inst_d <= inst_i;
    end
  end

  // ----------------------------------------
  // field extraction
  // ----------------------------------------

  assign opcode = opcode_e'(inst_d[6:0]);
  assign funct3 = inst_d[14:12];
  assign funct7 = inst_d[31:25];
  assign rd     = inst_d[11:7];
  assign rs1    = inst_d[19:15];
  assign rs2    = inst_d[24:20];

  // i-type sign extended, u-type upper 20 bits
  assign imm_i = {{20{inst_d[31]}}, inst_d[31:20]};
  assign imm_u = {inst_d[31:12], 12'b0};

  assign rs1_addr_o = rs1;
  assign rs2_addr_o = rs2;

  // funct3 to alu op, alt picks sub / sra
  function automatic alu_op_e alu_by_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return alt ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // ----------------------------------------
  // control decode
  // ----------------------------------------

  always_comb begin
    inst_ok = 1'b0;
    rs1_en  = 1'b0;
    rs2_en  = 1'b0;
    wen     = 1'b0;
    csrr    = 1'b0;
    csrw    = 1'b0;
    alu_op  = ALU_ADD;
    op_b    = rs2_data_i;
    case (opcode)
      OP_REG: begin
        // only add/sub and srl/sra have an alternate funct7
        inst_ok = (funct7 == F7_BASE) ||
                  ((funct7 == F7_ALT) && ((funct3 == F3_ADD) || (funct3 == F3_SR)));
        rs1_en  = 1'b1;
        rs2_en  = 1'b1;
        wen     = 1'b1;
        alu_op  = alu_by_f3(funct3, funct7[5]);
      end
      OP_IMM: begin
        // shifts carry funct7 in the upper immediate bits
        if (funct3 == F3_SLL) begin
          inst_ok = (funct7 == F7_BASE);
        end else if (funct3 == F3_SR) begin
          inst_ok = (funct7 == F7_BASE) || (funct7 == F7_ALT);
        end else begin
          inst_ok = 1'b1;
        end
        rs1_en = 1'b1;
        wen    = 1'b1;
        op_b   = imm_i;
        alu_op = alu_by_f3(funct3, (funct3 == F3_SR) && funct7[5]);
      end
      OP_LUI: begin
        inst_ok = 1'b1;
        wen     = 1'b1;
        op_b    = imm_u;
        alu_op  = ALU_CP_B;
      end
      OP_SYSTEM: begin
        if ((funct3 == F3_CSRRS) && (rs1 == 5'd0) &&
            (inst_d[31:20] == CSR_MNGR2PROC)) begin
          // csrr, manager data rides operand b
          inst_ok = 1'b1;
          csrr    = 1'b1;
          wen     = 1'b1;
          op_b    = mngr2proc_data_i;
          alu_op  = ALU_CP_B;
        end else if ((funct3 == F3_CSRRW) && (rd == 5'd0) &&
                     (inst_d[31:20] == CSR_PROC2MNGR)) begin
          // csrw, a + 0 carries rs1 to w
          inst_ok = 1'b1;
          csrw    = 1'b1;
          rs1_en  = 1'b1;
          op_b    = '0;
        end
      end
      default: begin
        inst_ok = 1'b0;
      end
    endcase
  end

  // ----------------------------------------
  // stall logic
  // ----------------------------------------

  // no bypass, wait until the producer has left w
  assign ostall_hazard = inst_ok &&
    ((rs1_en && x_wen_i && (rs1 == x_waddr_i)) ||
     (rs1_en && w_wen_i && (rs1 == w_waddr_i)) ||
     (rs2_en && x_wen_i && (rs2 == x_waddr_i)) ||
     (rs2_en && w_wen_i && (rs2 == w_waddr_i)));

  // csrr waits for manager data
  assign ostall_mngr = inst_ok && csrr && !mngr2proc_val_i;

  assign stall_d = val_d && (ostall_hazard || ostall_mngr || w_stall_i);

  // consume manager data only as the csrr moves to x
  assign mngr2proc_rdy_o = val_d && inst_ok && csrr && !stall_d;

  // ----------------------------------------
  // to x, bubble while stalled
  // ----------------------------------------

  assign dx_val_o    = val_d && !stall_d;
  assign dx_alu_op_o = alu_op;
  assign dx_op_a_o   = rs1_data_i;
  assign dx_op_b_o   = op_b;
  assign dx_wen_o    = inst_ok && wen;
  assign dx_waddr_o  = rd;
  assign dx_p2m_o    = inst_ok && csrw;

endmodule

// File: proc_execute.sv
// execute stage: x register and alu
// exposes its pending write to decode for the interlock

module proc_execute (
  input  logic                clk,
  input  logic                reset,
  // from decode
  input  logic                dx_val_i,
  input  proc_pkg::alu_op_e   dx_alu_op_i,
  input  proc_pkg::word_t     dx_op_a_i,
  input  proc_pkg::word_t     dx_op_b_i,
  input  logic                dx_wen_i,
  input  proc_pkg::reg_addr_t dx_waddr_i,
  input  logic                dx_p2m_i,
  input  logic                w_stall_i,
  // hazard info back to decode
  output logic                x_wen_o,
  output proc_pkg::reg_addr_t x_waddr_o,
  // to result
  output logic                xw_val_o,
  output proc_pkg::word_t     xw_result_o,
  output logic                xw_wen_o,
  output proc_pkg::reg_addr_t xw_waddr_o,
  output logic                xw_p2m_o
);

  import proc_pkg::*;

  logic      val_x;
  alu_op_e   alu_op_x;
  word_t     op_a_x;
  word_t     op_b_x;
  logic      wen_x;
  reg_addr_t waddr_x;
  logic      p2m_x;
  logic [4:0] shamt;

  // ----------------------------------------
  // x register, holds while w stalls
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      val_x <= 1'b0;
    end else if (!w_stall_i) begin
      val_x    <= dx_val_i;
      alu_op_x <= dx_alu_op_i;
      op_a_x   <= dx_op_a_i;
      op_b_x   <= dx_op_b_i;
      wen_x    <= dx_wen_i;
      waddr_x  <= dx_waddr_i;
      p2m_x    <= dx_p2m_i;
    end
  end

  // ----------------------------------------
  // alu
  // ----------------------------------------

  // shift amount from low 5 bits of b
  assign shamt = op_b_x[4:0];

  always_comb begin
    case (alu_op_x)
      ALU_ADD:  xw_result_o = op_a_x + op_b_x;
      ALU_SUB:  xw_result_o = op_a_x - op_b_x;
      ALU_AND:  xw_result_o = op_a_x & op_b_x;
      ALU_OR:   xw_result_o = op_a_x | op_b_x;
      ALU_XOR:  xw_result_o = op_a_x ^ op_b_x;
      ALU_SLT:  xw_result_o = {31'b0, $signed(op_a_x) < $signed(op_b_x)};
      ALU_SLTU: xw_result_o = {31'b0, op_a_x < op_b_x};
      ALU_SLL:  xw_result_o = op_a_x << shamt;
      ALU_SRL:  xw_result_o = op_a_x >> shamt;
      // arithmetic, sign bit fills from the left
      ALU_SRA:  xw_result_o = word_t'($signed(op_a_x) >>> shamt);
      default:  xw_result_o = op_b_x;
    endcase
  end

  // pending write, only real ones matter to the interlock
  assign x_wen_o   = val_x && wen_x && (waddr_x != 5'd0);
  assign x_waddr_o = waddr_x;

  // to w
  assign xw_val_o   = val_x;
  assign xw_wen_o   = wen_x;
  assign xw_waddr_o = waddr_x;
  assign xw_p2m_o   = p2m_x;

endmodule

// File: proc_result.sv
// result stage: w register, register file write and proc2mngr output
// a csrw sits here until the manager takes its value

module proc_result (
  input  logic                clk,
  input  logic                reset,
  // from execute
  input  logic                xw_val_i,
  input  proc_pkg::word_t     xw_result_i,
  input  logic                xw_wen_i,
  input  proc_pkg::reg_addr_t xw_waddr_i,
  input  logic                xw_p2m_i,
  // register file write, also seen by decode
  output logic                rf_wen_o,
  output proc_pkg::reg_addr_t rf_waddr_o,
  output proc_pkg::word_t     rf_wdata_o,
  // manager output stream
  output logic                proc2mngr_val_o,
  input  logic                proc2mngr_rdy_i,
  output proc_pkg::word_t     proc2mngr_data_o,
  output logic                w_stall_o
);

  import proc_pkg::*;

  logic      val_w;
  word_t     result_w;
  logic      wen_w;
  reg_addr_t waddr_w;
  logic      p2m_w;

  // ----------------------------------------
  // w register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      val_w <= 1'b0;
    end else if (!w_stall_o) begin
      val_w    <= xw_val_i;
      result_w <= xw_result_i;
      wen_w    <= xw_wen_i;
      waddr_w  <= xw_waddr_i;
      p2m_w    <= xw_p2m_i;
    end
  end

  // only back-pressure source in the pipe
  assign w_stall_o = val_w && p2m_w && !proc2mngr_rdy_i;

  // write back, x0 never written
  assign rf_wen_o   = val_w && wen_w && (waddr_w != 5'd0) && !w_stall_o;
  assign rf_waddr_o = waddr_w;
  assign rf_wdata_o = result_w;

  // valid held steady until the transfer
  assign proc2mngr_val_o  = val_w && p2m_w;
  assign proc2mngr_data_o = result_w;

endmodule

// File: proc_top.sv
// top level of the three-stage rv32 subset core
// instruction, manager input and manager output are valid/ready streams

module proc_top (
  input  logic            clk,
  input  logic            reset,
  // instruction stream
  input  logic            inst_val_i,
  output logic            inst_rdy_o,
  input  proc_pkg::word_t inst_i,
  // manager input
  input  logic            mngr2proc_val_i,
  output logic            mngr2proc_rdy_o,
  input  proc_pkg::word_t mngr2proc_data_i,
  // manager output
  output logic            proc2mngr_val_o,
  input  logic            proc2mngr_rdy_i,
  output proc_pkg::word_t proc2mngr_data_o
);

  import proc_pkg::*;

  // register file read
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;

  // d -> x
  logic      dx_val;
  alu_op_e   dx_alu_op;
  word_t     dx_op_a;
  word_t     dx_op_b;
  logic      dx_wen;
  reg_addr_t dx_waddr;
  logic      dx_p2m;

  // x -> w
  logic      xw_val;
  word_t     xw_result;
  logic      xw_wen;
  reg_addr_t xw_waddr;
  logic      xw_p2m;

  // hazard and stall paths
  logic      x_wen;
  reg_addr_t x_waddr;
  logic      rf_wen;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;
  logic      w_stall;

  // ----------------------------------------
  // stages
  // ----------------------------------------

  proc_decode decode0 (
    .clk              (clk),
    .reset            (reset),
    .inst_val_i       (inst_val_i),
    .inst_rdy_o       (inst_rdy_o),
    .inst_i           (inst_i),
    .mngr2proc_val_i  (mngr2proc_val_i),
    .mngr2proc_rdy_o  (mngr2proc_rdy_o),
    .mngr2proc_data_i (mngr2proc_data_i),
    .rs1_addr_o       (rs1_addr),
    .rs2_addr_o       (rs2_addr),
    .rs1_data_i       (rs1_data),
    .rs2_data_i       (rs2_data),
    .x_wen_i          (x_wen),
    .x_waddr_i        (x_waddr),
    .w_wen_i          (rf_wen),
    .w_waddr_i        (rf_waddr),
    .w_stall_i        (w_stall),
    .dx_val_o         (dx_val),
    .dx_alu_op_o      (dx_alu_op),
    .dx_op_a_o        (dx_op_a),
    .dx_op_b_o        (dx_op_b),
    .dx_wen_o         (dx_wen),
    .dx_waddr_o       (dx_waddr),
    .dx_p2m_o         (dx_p2m)
  );

  reg_file rf0 (
    .clk        (clk),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wen_i      (rf_wen),
    .waddr_i    (rf_waddr),
    .wdata_i    (rf_wdata)
  );

  proc_execute execute0 (
    .clk         (clk),
    .reset       (reset),
    .dx_val_i    (dx_val),
    .dx_alu_op_i (dx_alu_op),
    .dx_op_a_i   (dx_op_a),
    .dx_op_b_i   (dx_op_b),
    .dx_wen_i    (dx_wen),
    .dx_waddr_i  (dx_waddr),
    .dx_p2m_i    (dx_p2m),
    .w_stall_i   (w_stall),
    .x_wen_o     (x_wen),
    .x_waddr_o   (x_waddr),
    .xw_val_o    (xw_val),
    .xw_result_o (xw_result),
    .xw_wen_o    (xw_wen),
    .xw_waddr_o  (xw_waddr),
    .xw_p2m_o    (xw_p2m)
  );

  proc_result result0 (
    .clk              (clk),
    .reset            (reset),
    .xw_val_i         (xw_val),
    .xw_result_i      (xw_result),
    .xw_wen_i         (xw_wen),
    .xw_waddr_i       (xw_waddr),
    .xw_p2m_i         (xw_p2m),
    .rf_wen_o         (rf_wen),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata),
    .proc2mngr_val_o  (proc2mngr_val_o),
    .proc2mngr_rdy_i  (proc2mngr_rdy_i),
    .proc2mngr_data_o (proc2mngr_data_o),
    .w_stall_o        (w_stall)
  );

endmodule

// File: tb_proc_model.svh
// reference model of the rv32 subset and the random program generator
// included inside tb_proc, works on its model registers and queues
`ifndef TB_PROC_MODEL_SVH
`define TB_PROC_MODEL_SVH

// ----------------------------------------
// encoders for the kept formats
// ----------------------------------------

function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3, reg_addr_t rd);
  return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                reg_addr_t rd);
  return {imm, rs1, f3, rd, OP_IMM};
endfunction

function automatic word_t enc_lui(logic [19:0] imm, reg_addr_t rd);
  return {imm, rd, OP_LUI};
endfunction

// csrw is csrrw with rd = x0
function automatic word_t enc_csrw(reg_addr_t rs1);
  return {CSR_PROC2MNGR, rs1, F3_CSRRW, 5'd0, OP_SYSTEM};
endfunction

// csrr is csrrs with rs1 = x0
function automatic word_t enc_csrr(reg_addr_t rd);
  return {CSR_MNGR2PROC, 5'd0, F3_CSRRS, rd, OP_SYSTEM};
endfunction

// ----------------------------------------
// instruction semantics
// ----------------------------------------

// result by funct3, alt picks sub or the arithmetic shift
function automatic word_t alu_model(logic [2:0] f3, logic alt, word_t a, word_t b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// one accepted instruction, in program order
task automatic model_exec(input word_t inst);
  reg_addr_t rd;
  word_t     a;
  word_t     imm;
  word_t     res;
  logic      wr;
  rd  = inst[11:7];
  a   = mregs[inst[19:15]];
  imm = {{20{inst[31]}}, inst[31:20]};
  res = '0;
  wr  = 1'b0;
  case (inst[6:0])
    OP_REG: begin
      res = alu_model(inst[14:12], inst[30], a, mregs[inst[24:20]]);
      wr  = 1'b1;
    end
    OP_IMM: begin
      // only srai has an alternate form
      res = alu_model(inst[14:12], (inst[14:12] == 3'd5) && inst[30], a, imm);
      wr  = 1'b1;
    end
    OP_LUI: begin
      res = {inst[31:12], 12'b0};
      wr  = 1'b1;
    end
    OP_SYSTEM: begin
      if (inst[31:20] == CSR_MNGR2PROC) begin
        // next manager word, even when rd is x0
        res = mngr_vals[m_model_idx];
        m_model_idx++;
        wr  = 1'b1;
      end else begin
        exp_q.push_back(a);
      end
    end
    default: begin
    end
  endcase
  if (wr && (rd != 5'd0)) begin
    mregs[rd] = res;
  end
endtask

// ----------------------------------------
// random generator
// ----------------------------------------

// half the picks from x0..x7 so dependences come close together
function automatic reg_addr_t pick_reg();
  if ($urandom_range(0, 1) == 0) begin
    return reg_addr_t'($urandom_range(0, 7));
  end
  return reg_addr_t'($urandom_range(0, 31));
endfunction

// about 10% csrw, 5% csrr, then reg-reg, reg-imm and lui
function automatic word_t gen_random_inst();
  int unsigned sel;
  logic [2:0]  f3;
  logic        alt;
  logic [11:0] imm;
  sel = $urandom_range(0, 99);
  f3  = 3'($urandom_range(0, 7));
  alt = 1'($urandom_range(0, 1));
  if (sel < 10) begin
    return enc_csrw(pick_reg());
  end
  if (sel < 15) begin
    return enc_csrr(pick_reg());
  end
  if (sel < 50) begin
    // alternate funct7 only for sub and sra
    alt = alt && ((f3 == 3'd0) || (f3 == 3'd5));
    return enc_r(alt ? F7_ALT : F7_BASE, pick_reg(), pick_reg(), f3, pick_reg());
  end
  if (sel < 90) begin
    imm = 12'($urandom());
    // shift immediates carry funct7 on top of a 5 bit amount
    if (f3 == 3'd1) begin
      imm[11:5] = F7_BASE;
    end
    if (f3 == 3'd5) begin
      imm[11:5] = alt ? F7_ALT : F7_BASE;
    end
    return enc_i(imm, pick_reg(), f3, pick_reg());
  end
  return enc_lui(20'($urandom()), pick_reg());
endfunction

`endif

// File: tb_proc.sv
// testbench for proc_top: random rv32 subset program checked against a model
// build and run with run.sh, model and generator live in tb_proc_model.svh

module tb_proc;

  import proc_pkg::*;

  localparam int NUM_RANDOM      = 2000;
  localparam int CYCLES_PER_INST = 40;

  logic  clk;
  logic  reset;
  logic  inst_val_i;
  logic  inst_rdy_o;
  word_t inst_i;
  logic  mngr2proc_val_i;
  logic  mngr2proc_rdy_o;
  word_t mngr2proc_data_i;
  logic  proc2mngr_val_o;
  logic  proc2mngr_rdy_i;
  word_t proc2mngr_data_o;

  // model state
  word_t mregs [32];
  word_t exp_q [$];
  word_t prog [$];
  word_t mngr_vals [NUM_RANDOM];
  int    m_model_idx;
  int    m_drv_idx;
  int    prog_idx;
  int    cycle_cnt;
  int    cycle_limit;

  // transfers due at the coming edge, sampled while the pipe is settled
  logic  inst_fire;
  logic  m2p_fire;
  logic  p2m_fire;

  `include "tb_proc_model.svh"

  proc_top dut0 (
    .clk              (clk),
    .reset            (reset),
    .inst_val_i       (inst_val_i),
    .inst_rdy_o       (inst_rdy_o),
    .inst_i           (inst_i),
    .mngr2proc_val_i  (mngr2proc_val_i),
    .mngr2proc_rdy_o  (mngr2proc_rdy_o),
    .mngr2proc_data_i (mngr2proc_data_i),
    .proc2mngr_val_o  (proc2mngr_val_o),
    .proc2mngr_rdy_i  (proc2mngr_rdy_i),
    .proc2mngr_data_o (proc2mngr_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------

  task automatic stop_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic fail_now(input string why);
    $display("error at time %0t: %s", $time, why);
    stop_run();
  endtask

  // empty pipe, nothing offered or taken
  task automatic check_idle(input string when);
    check(32'(proc2mngr_val_o), 32'd0, {"proc2mngr_val_o ", when});
    check(32'(mngr2proc_rdy_o), 32'd0, {"mngr2proc_rdy_o ", when});
    check(32'(inst_rdy_o), 32'd1, {"inst_rdy_o ", when});
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  // register init by lui + addi, random body, csrw drain of x1..x31
  task automatic build_program();
    for (int r = 1; r < 32; r++) begin
      prog.push_back(enc_lui(20'($urandom()), reg_addr_t'(r)));
      prog.push_back(enc_i(12'($urandom()), reg_addr_t'(r), 3'd0, reg_addr_t'(r)));
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      prog.push_back(gen_random_inst());
    end
    for (int r = 1; r < 32; r++) begin
      prog.push_back(enc_csrw(reg_addr_t'(r)));
    end
  endtask

  // valid holds with its data until the transfer
  task automatic drive_inputs();
    if (!inst_val_i || inst_fire) begin
      if ((prog_idx < prog.size()) && ($urandom_range(0, 9) < 8)) begin
        inst_val_i = 1'b1;
        inst_i     = prog[prog_idx];
      end else begin
        inst_val_i = 1'b0;
      end
    end
    if (!mngr2proc_val_i || m2p_fire) begin
      if ((m_drv_idx < NUM_RANDOM) && ($urandom_range(0, 1) == 1)) begin
        mngr2proc_val_i  = 1'b1;
        mngr2proc_data_i = mngr_vals[m_drv_idx];
      end else begin
        mngr2proc_val_i = 1'b0;
      end
    end
    // about 70% ready
    proc2mngr_rdy_i = ($urandom_range(0, 9) < 7);
  endtask

  // outputs first, so a new instruction cannot cover a missing one
  task automatic sample_edge();
    inst_fire = inst_val_i && inst_rdy_o;
    m2p_fire  = mngr2proc_val_i && mngr2proc_rdy_o;
    p2m_fire  = proc2mngr_val_o && proc2mngr_rdy_i;
    if (p2m_fire) begin
      if (exp_q.size() == 0) begin
        fail_now("proc2mngr output with no csrw outstanding");
      end else begin
        check(proc2mngr_data_o, exp_q.pop_front(), "csrw output");
      end
    end
    if (m2p_fire) begin
      if (m_drv_idx >= m_model_idx) begin
        fail_now("manager input taken with no csrr waiting for it");
      end else begin
        m_drv_idx++;
      end
    end
    if (inst_fire) begin
      model_exec(prog[prog_idx]);
      prog_idx++;
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    void'($urandom(32'heaf9));
    reset            = 1'b1;
    inst_val_i       = 1'b0;
    inst_i           = '0;
    mngr2proc_val_i  = 1'b0;
    mngr2proc_data_i = '0;
    proc2mngr_rdy_i  = 1'b0;
    inst_fire        = 1'b0;
    m2p_fire         = 1'b0;
    p2m_fire         = 1'b0;
    m_model_idx      = 0;
    m_drv_idx        = 0;
    prog_idx         = 0;
    cycle_cnt        = 0;
    for (int r = 0; r < 32; r++) begin
      mregs[r] = '0;
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      mngr_vals[i] = $urandom();
    end
    build_program();
    cycle_limit = CYCLES_PER_INST * prog.size();

    // ten reset edges, state looked at once each edge has settled
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1;
      check_idle("during reset");
    end
    reset = 1'b0;
    @(posedge clk);
    #1;
    check_idle("after reset");
    drive_inputs();

    // until every instruction is in and every csrw is out
    while (((prog_idx < prog.size()) || (exp_q.size() != 0)) &&
           (cycle_cnt < cycle_limit)) begin
      @(negedge clk);
      sample_edge();
      @(posedge clk);
      cycle_cnt++;
      #1;
      drive_inputs();
    end

    if ((prog_idx < prog.size()) || (exp_q.size() != 0)) begin
      $display("timeout after %0d cycles: %0d of %0d accepted, %0d outputs pending",
               cycle_cnt, prog_idx, prog.size(), exp_q.size());
      stop_run();
    end else begin
      check(32'(m_drv_idx), 32'(m_model_idx), "manager inputs consumed");
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// File: src.f
+incdir+.
proc_pkg.sv
reg_file.sv
proc_decode.sv
proc_execute.sv
proc_result.sv
proc_top.sv
tb_proc.sv

// File: run.sh
#!/bin/sh
# compile with verilator and run the testbench, status 0 only on a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_proc -o tb_proc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/tb_proc_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
